// File: bench/memPipeTb.sv
/*
  Testbench of the memory pipe. A sequential model predicts every result at
  issue time; flush and clear are kept stable while affected ops are in flight.
  Data values come from 5-bit CSR immediates, the only source of new data.
*/
`timescale 1ns/1ps
`default_nettype none

`include "memPipe_defs.svh"

module memPipeTb;

    import memOpPkg::*;
    import memPipePkg::*;

    localparam int CLOCK_PERIOD = 4;
    localparam int RESET_CYCLES = 10;
    localparam int STORE_WORDS = `MEM_PIPE_MEM_WORDS;
    localparam int LOAD_OPS = 32;
    localparam int FWD_OPS = 40;
    localparam int CSR_OPS = 24;
    localparam int FLUSH_OPS = 40;
    localparam int STALL_OPS = 60;
    // Stalled ops may take several cycles, drains take up to 20 each
    localparam int STIM_CYCLES = RESET_CYCLES + 3 * STORE_WORDS + LOAD_OPS + FWD_OPS
        + 2 * CSR_OPS + FLUSH_OPS + 30 + STORE_WORDS + 4 * STALL_OPS + 6 * 40;
    localparam int WATCHDOG_NS = STIM_CYCLES * CLOCK_PERIOD + 400;

    logic clock;
    logic reset;
    logic stall;
    logic clear;
    MemIssueOp issueOp;
    FlushRange flushRange;
    MemResult result;

    DataPath modelRegs [`MEM_PIPE_REG_NUM];
    DataPath modelMem [`MEM_PIPE_MEM_WORDS];
    DataPath modelCsr [4];
    bit pendHas [$];
    RegIndex pendDest [$];
    DataPath pendData [$];
    RegIndex expDest [$];
    DataPath expData [$];
    int expEdge [$];
    RegIndex eDest;
    DataPath eData;
    int eEdge;
    int edgeCount;
    int errorCount;
    int checkCount;
    int testCount;
    int testStartErrors;
    int stallRate;
    string testName;

    memPipeTop memPipeTop_i (
        .clock(clock), .reset(reset), .stall(stall), .clear(clear),
        .issueOp(issueOp), .flushRange(flushRange), .result(result)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired after %0d ns, pipe stopped producing results",
            WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

    function automatic MemIssueOp makeOp(input MemOpType t, input RegIndex d, input RegIndex a,
        input RegIndex b, input ImmPath imm, input CsrCode c, input logic useImm,
        input CsrImmPath ci, input TagPath tag);
        MemIssueOp op;
        op = '{valid: 1'b1, opType: t, destReg: d, srcRegA: a, srcRegB: b, imm: imm,
            csrCode: c, csrUseImm: useImm, csrImm: ci, tag: tag};
        return op;
    endfunction

    // Head inclusive, tail exclusive, wrapping at the tag width
    function automatic bit tagFlushed(input FlushRange fr, input TagPath tag);
        TagPath offset;
        TagPath span;
        offset = tag - fr.headTag;
        span = fr.tailTag - fr.headTag;
        return fr.flushAll || (fr.flushActive && offset < span);
    endfunction

    task automatic modelOp(input MemIssueOp op, output bit hasRes, output DataPath data);
        DataPath base;
        DataPath offset;
        DataPath operand;
        int addr;
        logic [1:0] idx;
        hasRes = 1'b0;
        data = '0;
        base = modelRegs[op.srcRegA];
        offset = DataPath'(int'(signed'(op.imm)));
        addr = int'((base + offset) % DataPath'(`MEM_PIPE_MEM_WORDS));
        idx = op.imm[1:0];
        operand = op.csrUseImm ? DataPath'(op.csrImm) : base;
        case (op.opType)
            OP_LOAD: begin
                data = modelMem[addr];
                hasRes = 1'b1;
            end
            OP_STORE: modelMem[addr] = modelRegs[op.srcRegB];
            OP_CSR: begin
                data = modelCsr[idx];
                hasRes = 1'b1;
                if (op.csrCode == CSR_WRITE) modelCsr[idx] = operand;
                else if (op.csrCode == CSR_SET) modelCsr[idx] = data | operand;
                else modelCsr[idx] = data & ~operand;
            end
            default: hasRes = 1'b0;
        endcase
        if (hasRes && op.destReg != '0) modelRegs[op.destReg] = data;
    endtask

    // Holds the op on the inputs through random stall cycles
    task automatic sendOp(input MemIssueOp op, input bit dropped);
        bit hasRes;
        DataPath data;
        bit stallNow;
        hasRes = 1'b0;
        data = '0;
        if (!dropped) modelOp(op, hasRes, data);
        pendHas.push_back(hasRes);
        pendDest.push_back(op.destReg);
        pendData.push_back(data);
        do begin
            stallNow = int'($urandom_range(99)) < stallRate;
            @(posedge clock);
            stall <= stallNow;
            issueOp <= op;
        end while (stallNow);
    endtask

    task automatic sendIdle();
        @(posedge clock);
        stall <= 1'b0;
        clear <= 1'b0;
        issueOp <= '0;
    endtask

    task automatic loadRegImm(input RegIndex r, input CsrImmPath value);
        sendOp(makeOp(OP_CSR, '0, '0, '0, ImmPath'(3), CSR_WRITE, 1'b1, value, '0), 1'b0);
        sendOp(makeOp(OP_CSR, r, '0, '0, ImmPath'(3), CSR_SET, 1'b1, '0, '0), 1'b0);
    endtask

    task automatic drainPipe();
        int n;
        n = 0;
        while ((pendHas.size() != 0 || expDest.size() != 0) && n < 20) begin
            sendIdle();
            n++;
        end
        assert (pendHas.size() == 0 && expDest.size() == 0) else begin
            $display("ERROR: %s: %0d results never appeared", testName, expDest.size());
            errorCount++;
        end
        repeat (2) sendIdle();
    endtask

    task automatic finishTest();
        int errs;
        errs = errorCount - testStartErrors;
        $display("test %-10s %s (%0d errors)", testName, errs == 0 ? "ok" : "failed", errs);
        testCount++;
        testStartErrors = errorCount;
    endtask

    // Issue sampling and unstalled edge count
    always @(posedge clock) begin
        if (!reset && !stall) begin
            edgeCount++;
            if (issueOp.valid && pendHas.size() != 0) begin
                if (pendHas.pop_front()) begin
                    expDest.push_back(pendDest.pop_front());
                    expData.push_back(pendData.pop_front());
                    expEdge.push_back(edgeCount);
                end else begin
                    void'(pendDest.pop_front());
                    void'(pendData.pop_front());
                end
            end
        end
    end

    always @(negedge clock) begin
        if (!reset && result.valid) begin
            checkCount++;
            assert (expDest.size() != 0) else begin
                $display("ERROR: %s: result appeared with none expected", testName);
                errorCount++;
            end
            if (expDest.size() != 0) begin
                eDest = expDest.pop_front();
                eData = expData.pop_front();
                eEdge = expEdge.pop_front();
                assert (result.destReg === eDest && result.data === eData) else begin
                    $display("MISMATCH %s: expected r%0d=%h actual r%0d=%h", testName,
                        eDest, eData, result.destReg, result.data);
                    errorCount++;
                end
                assert (edgeCount - eEdge + 1 == 3) else begin
                    $display("MISMATCH %s: latency expected 3 actual %0d", testName,
                        edgeCount - eEdge + 1);
                    errorCount++;
                end
            end
        end
    end

    initial begin
        RegIndex prevDest;
        RegIndex prev2Dest;
        RegIndex d;
        MemIssueOp op;
        FlushRange fr;
        TagPath head;
        logic [1:0] idx;
        ImmPath imm;
        void'($urandom(32'hadac957e));
        reset = 1'b1;
        stall = 1'b0;
        clear = 1'b0;
        issueOp = '0;
        flushRange = '0;
        stallRate = 0;
        edgeCount = 0;
        errorCount = 0;
        checkCount = 0;
        testCount = 0;
        testStartErrors = 0;
        for (int i = 0; i < `MEM_PIPE_REG_NUM; i++) modelRegs[i] = '0;
        for (int i = 0; i < `MEM_PIPE_MEM_WORDS; i++) modelMem[i] = '0;
        for (int i = 0; i < 4; i++) modelCsr[i] = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;

        testName = "reset";
        repeat (8) begin
            @(negedge clock);
            assert (result.valid === 1'b0) else begin
                $display("ERROR: result valid before any issue");
                errorCount++;
            end
        end
        finishTest();

        // Every word gets stored, so later loads never see undefined memory
        testName = "storeLoad";
        for (int w = 0; w < STORE_WORDS; w++) begin
            loadRegImm(RegIndex'(2), CsrImmPath'($urandom));
            imm = $urandom_range(1) ? ImmPath'(w) : ImmPath'(w - STORE_WORDS);
            sendOp(makeOp(OP_STORE, '0, '0, RegIndex'(2), imm, CSR_WRITE, 1'b0, '0, '0), 1'b0);
        end
        for (int i = 0; i < LOAD_OPS; i++) begin
            op = makeOp(OP_LOAD, RegIndex'($urandom_range(7, 1)), '0, '0, ImmPath'($urandom),
                CSR_WRITE, 1'b0, '0, '0);
            sendOp(op, 1'b0);
        end
        drainPipe();
        finishTest();

        testName = "forward";
        prevDest = RegIndex'(1);
        prev2Dest = RegIndex'(2);
        for (int i = 0; i < FWD_OPS; i++) begin
            d = RegIndex'($urandom_range(7, 1));
            if ($urandom_range(3) == 0) begin
                op = makeOp(OP_STORE, '0, prevDest, d, ImmPath'($urandom), CSR_WRITE,
                    1'b0, '0, '0);
            end else begin
                op = makeOp(OP_LOAD, d, (i % 2 == 0) ? prevDest : prev2Dest, '0,
                    ImmPath'($urandom), CSR_WRITE, 1'b0, '0, '0);
                prev2Dest = prevDest;
                prevDest = d;
            end
            sendOp(op, 1'b0);
        end
        drainPipe();
        finishTest();

        testName = "csr";
        for (int i = 0; i < CSR_OPS; i++) begin
            idx = 2'($urandom);
            imm = ImmPath'($urandom);
            imm[1:0] = idx;
            op = makeOp(OP_CSR, RegIndex'($urandom_range(7, 1)), RegIndex'($urandom), '0, imm,
                CsrCode'(i % 3), 1'((i / 3) % 2), CsrImmPath'($urandom), '0);
            sendOp(op, 1'b0);
            // Read back with a set of nothing
            sendOp(makeOp(OP_CSR, RegIndex'($urandom_range(7, 1)), '0, '0, imm, CSR_SET,
                1'b1, '0, '0), 1'b0);
        end
        drainPipe();
        finishTest();

        testName = "flush";
        head = TagPath'($urandom);
        fr = '{flushAll: 1'b0, flushActive: 1'b1, headTag: head, tailTag: TagPath'(head + 5)};
        for (int pass = 0; pass < 2; pass++) begin
            @(posedge clock);
            flushRange <= fr;
            for (int i = 0; i < FLUSH_OPS / 2; i++) begin
                op = makeOp($urandom_range(1) ? OP_LOAD : OP_STORE,
                    RegIndex'($urandom_range(7, 1)), '0, RegIndex'($urandom),
                    ImmPath'($urandom), CSR_WRITE, 1'b0, '0, TagPath'($urandom));
                sendOp(op, tagFlushed(fr, op.tag));
            end
            drainPipe();
            fr = '{flushAll: 1'b1, flushActive: 1'b0, headTag: '0, tailTag: '0};
        end
        @(posedge clock);
        flushRange <= '0;
        // Stores in execution, in register read and on the inputs are all lost on clear
        imm = ImmPath'($urandom);
        loadRegImm(RegIndex'(5), CsrImmPath'(~modelMem[int'(imm) % STORE_WORDS]));
        op = makeOp(OP_STORE, '0, '0, RegIndex'(5), imm, CSR_WRITE, 1'b0, '0, '0);
        repeat (3) sendOp(op, 1'b1);
        clear <= 1'b1;
        sendIdle();
        sendOp(makeOp(OP_LOAD, RegIndex'(3), '0, '0, imm, CSR_WRITE, 1'b0, '0, '0), 1'b0);
        for (int w = 0; w < STORE_WORDS; w++) begin
            sendOp(makeOp(OP_LOAD, RegIndex'(4), '0, '0, ImmPath'(w), CSR_WRITE, 1'b0, '0, '0),
                1'b0);
        end
        drainPipe();
        finishTest();

        testName = "stall";
        stallRate = 35;
        for (int i = 0; i < STALL_OPS; i++) begin
            op = makeOp(MemOpType'($urandom_range(3, 1)), RegIndex'($urandom_range(7, 1)),
                RegIndex'($urandom), RegIndex'($urandom), ImmPath'($urandom),
                CsrCode'($urandom_range(2)), 1'($urandom), CsrImmPath'($urandom), '0);
            sendOp(op, 1'b0);
        end
        stallRate = 0;
        drainPipe();
        finishTest();

        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+hw
hw/memOpPkg.sv
hw/memPipePkg.sv
hw/memRegReadStage.sv
hw/memExecStage.sv
hw/memAccessStage.sv
hw/csrFile.sv
hw/memPipeTop.sv
bench/memPipeTb.sv

// File: hw/csrFile.sv
/*
  Four control/status registers, selected by the low 2 bits of the CSR number.
  Read is combinational, so the old value is seen in the cycle of the write.
*/
`timescale 1ns/1ps
`default_nettype none

module csrFile (
    input  logic              clock,
    input  logic              reset,
    input  logic              csrWe,
    input  memOpPkg::ImmPath  csrNumber,
    input  memOpPkg::CsrCode  csrCode,
    input  memOpPkg::DataPath csrWriteData,
    output memOpPkg::DataPath csrReadData
);

    import memOpPkg::*;

    DataPath csrRegs [4];
    logic [1:0] csrIndex;

    always_comb begin
        csrIndex = csrNumber[1:0];
        csrReadData = csrRegs[csrIndex];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                csrRegs[i] <= '0;
            end
        end else if (csrWe) begin
            case (csrCode)
                CSR_WRITE: csrRegs[csrIndex] <= csrWriteData;
                CSR_SET:   csrRegs[csrIndex] <= csrRegs[csrIndex] | csrWriteData;
                CSR_CLEAR: csrRegs[csrIndex] <= csrRegs[csrIndex] & ~csrWriteData;
                default:   csrRegs[csrIndex] <= csrRegs[csrIndex];
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/memAccessStage.sv
/*
  Access stage with a word-addressed data memory. Stores write at the edge,
  loads and CSR ops register their data into the result. The memory has no
  reset, so a load from a word never stored returns an undefined value.
*/
`timescale 1ns/1ps
`default_nettype none

`include "memPipe_defs.svh"

module memAccessStage (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      stall,
    input  memPipePkg::AccessStageReg accessReg,
    output memPipePkg::MemResult      result
);

    import memOpPkg::*;

    DataPath dataMem [`MEM_PIPE_MEM_WORDS];
    DataPath loadWord;
    DataPath resultData;
    logic isLoad;
    logic isStore;
    logic isCsr;
    logic hasResult;

    always_comb begin
        isLoad = (accessReg.opType == OP_LOAD);
        isStore = (accessReg.opType == OP_STORE);
        isCsr = (accessReg.opType == OP_CSR);
        hasResult = accessReg.valid && (isLoad || isCsr);

        loadWord = dataMem[accessReg.addr];

        // CSR ops carry the old CSR value in the store data field
        if (isCsr) begin
            resultData = accessReg.storeData;
        end else begin
            resultData = loadWord;
        end
    end

    // Store port
    always_ff @(posedge clock) begin
        if (!stall && accessReg.valid && isStore) begin
            dataMem[accessReg.addr] <= accessReg.storeData;
        end
    end

    // Result register, holds while stalled
    always_ff @(posedge clock) begin
        if (reset) begin
            result.valid <= 1'b0;
        end else if (!stall) begin
            result.valid <= hasResult;
            result.destReg <= accessReg.destReg;
            result.data <= resultData;
        end
    end

endmodule

`default_nettype wire

// File: hw/memExecStage.sv
/*
  Execution stage of the memory pipe. Address is base plus the sign-extended
  offset, wrapped to the memory depth. Operands are forwarded from the result
  one stage ahead. A flushed, stalled or cleared op leaves no valid record and
  raises no CSR write. Only one CSR op can be in flight here.
*/
`timescale 1ns/1ps
`default_nettype none

`include "memPipe_defs.svh"

module memExecStage (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      stall,
    input  logic                      clear,
    input  memPipePkg::ExecStageReg   execReg,
    input  memPipePkg::FlushRange     flushRange,
    input  memPipePkg::MemResult      result,
    input  memOpPkg::DataPath         csrReadData,
    output logic                      csrWe,
    output memOpPkg::ImmPath          csrNumber,
    output memOpPkg::CsrCode          csrCode,
    output memOpPkg::DataPath         csrWriteData,
    output memPipePkg::AccessStageReg accessReg
);

    import memOpPkg::*;
    import memPipePkg::*;

    ExecStageReg pipeReg;
    MemIssueOp op;
    DataPath fuOpA;
    DataPath fuOpB;
    DataPath addrSum;
    logic flush;
    logic isCsr;

    // Circular range check, empty when head equals tail
    function automatic logic inFlushRange(input FlushRange range, input TagPath tag);
        logic hit;
        if (range.headTag <= range.tailTag) begin
            hit = (tag >= range.headTag) && (tag < range.tailTag);
        end else begin
            hit = (tag >= range.headTag) || (tag < range.tailTag);
        end
        return hit;
    endfunction

    always_ff @(posedge clock) begin
        if (reset || clear) begin
            pipeReg.op.valid <= 1'b0;
        end else if (!stall) begin
            pipeReg <= execReg;
        end
    end

    always_comb begin
        op = pipeReg.op;

        flush = flushRange.flushAll ||
            (flushRange.flushActive && inFlushRange(flushRange, op.tag));

        // Bypass from the access stage result
        if (result.valid && result.destReg != '0 && result.destReg == op.srcRegA) begin
            fuOpA = result.data;
        end else begin
            fuOpA = pipeReg.operandA;
        end
        if (result.valid && result.destReg != '0 && result.destReg == op.srcRegB) begin
            fuOpB = result.data;
        end else begin
            fuOpB = pipeReg.operandB;
        end

        addrSum = fuOpA + {{(`MEM_PIPE_DATA_WIDTH - `MEM_PIPE_IMM_WIDTH)
            {op.imm[`MEM_PIPE_IMM_WIDTH-1]}}, op.imm};

        // CSR request
        isCsr = (op.opType == OP_CSR);
        csrWe = op.valid && isCsr && !flush && !stall && !clear;
        csrNumber = op.imm;
        csrCode = op.csrCode;
        csrWriteData = op.csrUseImm ? DataPath'(op.csrImm) : fuOpA;

        // Record for the access stage
        accessReg.valid = (stall || clear || flush) ? 1'b0 : op.valid;
        accessReg.opType = op.opType;
        accessReg.destReg = op.destReg;
        accessReg.addr = addrSum[$bits(WordAddr)-1:0];
        accessReg.storeData = isCsr ? csrReadData : fuOpB;
        accessReg.csrWriteData = csrWriteData;
    end

endmodule

`default_nettype wire

// File: hw/memOpPkg.sv
/*
  Types of the issued memory micro-op.
  The imm field holds the address offset, or the CSR number for CSR ops.
*/
`default_nettype none

`include "memPipe_defs.svh"

package memOpPkg;

    typedef logic [`MEM_PIPE_DATA_WIDTH-1:0] DataPath;
    typedef logic [$clog2(`MEM_PIPE_REG_NUM)-1:0] RegIndex;
    typedef logic [`MEM_PIPE_IMM_WIDTH-1:0] ImmPath;
    typedef logic [`MEM_PIPE_TAG_WIDTH-1:0] TagPath;
    typedef logic [4:0] CsrImmPath;

    typedef enum logic [1:0] {
        OP_NOP,
        OP_LOAD,
        OP_STORE,
        OP_CSR
    } MemOpType;

    typedef enum logic [1:0] {
        CSR_WRITE,
        CSR_SET,
        CSR_CLEAR
    } CsrCode;

    typedef struct packed {
        logic valid;
        MemOpType opType;
        RegIndex destReg;
        RegIndex srcRegA;
        RegIndex srcRegB;
        ImmPath imm;
        CsrCode csrCode;
        logic csrUseImm;
        CsrImmPath csrImm;
        TagPath tag;
    } MemIssueOp;

endpackage

`default_nettype wire

// File: hw/memPipePkg.sv
/*
  Records passed between the pipe stages, the flush range and the result.
  Word addresses wrap at the data memory depth.
*/
`default_nettype none

`include "memPipe_defs.svh"

package memPipePkg;

    import memOpPkg::*;

    typedef logic [$clog2(`MEM_PIPE_MEM_WORDS)-1:0] WordAddr;

    // Register read to execution
    typedef struct packed {
        MemIssueOp op;
        DataPath operandA;
        DataPath operandB;
    } ExecStageReg;

    // Execution to access; storeData holds the old CSR value for CSR ops
    typedef struct packed {
        logic valid;
        MemOpType opType;
        RegIndex destReg;
        WordAddr addr;
        DataPath storeData;
        DataPath csrWriteData;
    } AccessStageReg;

    // Tag range is circular, head inclusive and tail exclusive
    typedef struct packed {
        logic flushAll;
        logic flushActive;
        TagPath headTag;
        TagPath tailTag;
    } FlushRange;

    typedef struct packed {
        logic valid;
        RegIndex destReg;
        DataPath data;
    } MemResult;

endpackage

`default_nettype wire

// File: hw/memPipeTop.sv
/*
  Memory execution pipe. Results appear 3 unstalled edges after issue.
  The source must hold issueOp while stall is high.
*/
`timescale 1ns/1ps
`default_nettype none

module memPipeTop (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  clear,
    input  memOpPkg::MemIssueOp   issueOp,
    input  memPipePkg::FlushRange flushRange,
    output memPipePkg::MemResult  result
);

    import memOpPkg::*;
    import memPipePkg::*;

    ExecStageReg execReg;
    AccessStageReg accessReg;
    MemResult accessResult;
    logic csrWe;
    ImmPath csrNumber;
    CsrCode csrCode;
    DataPath csrWriteData;
    DataPath csrReadData;

    // A held result shows once, when the stall drops
    always_comb begin
        result = accessResult;
        result.valid = accessResult.valid && !stall;
    end

    memRegReadStage regReadStage_i (
        .clock(clock), .reset(reset), .stall(stall), .clear(clear),
        .issueOp(issueOp), .result(result), .execReg(execReg)
    );

    memExecStage execStage_i (
        .clock(clock), .reset(reset), .stall(stall), .clear(clear),
        .execReg(execReg), .flushRange(flushRange), .result(result),
        .csrReadData(csrReadData), .csrWe(csrWe), .csrNumber(csrNumber),
        .csrCode(csrCode), .csrWriteData(csrWriteData), .accessReg(accessReg)
    );

    memAccessStage accessStage_i (
        .clock(clock), .reset(reset), .stall(stall),
        .accessReg(accessReg), .result(accessResult)
    );

    csrFile csrFile_i (
        .clock(clock), .reset(reset), .csrWe(csrWe), .csrNumber(csrNumber),
        .csrCode(csrCode), .csrWriteData(csrWriteData), .csrReadData(csrReadData)
    );

endmodule

`default_nettype wire

// File: hw/memPipe_defs.svh
/*
  Sizing of the memory pipe. The register count and the memory depth
  must be powers of two, and the data width must exceed the offset width.
*/
`ifndef MEM_PIPE_DEFS_SVH
`define MEM_PIPE_DEFS_SVH

// Data path and register width
`define MEM_PIPE_DATA_WIDTH 32

// Architectural registers, register 0 reads as zero
`define MEM_PIPE_REG_NUM 8

// Data memory depth in words
`define MEM_PIPE_MEM_WORDS 64

`define MEM_PIPE_TAG_WIDTH 4

// Offset field, also used as the CSR number
`define MEM_PIPE_IMM_WIDTH 12

`endif

// File: hw/memRegReadStage.sv
/*
  Register read stage. The issued op is latched on unstalled edges and its
  sources are read from the latched op, so a result that is visible in the
  same cycle is forwarded. The result strobe must already be masked by stall.
*/
`timescale 1ns/1ps
`default_nettype none

`include "memPipe_defs.svh"

module memRegReadStage (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    stall,
    input  logic                    clear,
    input  memOpPkg::MemIssueOp     issueOp,
    input  memPipePkg::MemResult    result,
    output memPipePkg::ExecStageReg execReg
);

    import memOpPkg::*;

    MemIssueOp opReg;
    DataPath regFile [`MEM_PIPE_REG_NUM];

    // Read port with bypass from the result register
    function automatic DataPath readReg(input RegIndex idx);
        DataPath value;
        if (idx == '0) begin
            value = '0;
        end else if (result.valid && result.destReg == idx) begin
            value = result.data;
        end else begin
            value = regFile[idx];
        end
        return value;
    endfunction

    // Pipeline register
    always_ff @(posedge clock) begin
        if (reset || clear) begin
            opReg.valid <= 1'b0;
        end else if (!stall) begin
            opReg <= issueOp;
        end
    end

    // Write back of loads and CSR old values
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `MEM_PIPE_REG_NUM; i++) begin
                regFile[i] <= '0;
            end
        end else if (result.valid && result.destReg != '0) begin
            regFile[result.destReg] <= result.data;
        end
    end

    always_comb begin
        execReg.op = opReg;
        execReg.operandA = readReg(opReg.srcRegA);
        execReg.operandB = readReg(opReg.srcRegB);
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Builds and runs the memory pipe testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module memPipeTb \
    -o memPipeSim > build.log 2>&1
status=$?
cat build.log
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/memPipeSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
